// File: project.f
+incdir+verilog
verilog/mem_addr_pkg.sv
verilog/mem_fsm_pkg.sv
verilog/bram_dpge.sv
verilog/memory_ctrl.sv
verilog/mem_subsystem.sv
verification/tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and decide pass or fail from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_mem_subsystem -f project.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1

// File: verification/tb_mem_subsystem.sv
// testbench for the byte-addressed memory subsystem
// table of reads, writes and streams checked against a byte-array model
`include "mem_consts.svh"

module tb_mem_subsystem;

  localparam int OP_READ       = 0;
  localparam int OP_WRITE      = 1;
  localparam int OP_STREAM     = 2;
  localparam int OP_BAD_STREAM = 3;
  localparam int MAX_ENTRIES   = 40;
  localparam int NUM_WORDS     = 2 ** `MEM_ADDR_WIDTH;
  localparam int MEM_BYTES     = 8 * NUM_WORDS;
  localparam int ADDR_BITS     = mem_addr_pkg::BYTE_ADDR_BITS;
  localparam logic [63:0] INIT_WORD = `MEM_INIT_VALUE;

  logic                     i_clk;
  logic                     i_areset;
  logic                     i_read_64;
  logic                     i_write_64;
  logic [63:0]              i_write_data;
  mem_addr_pkg::byte_addr_u i_byte_addr;
  logic                     o_busy;
  logic                     o_error;
  logic [63:0]              o_data;

  // byte b of the model is byte b of the memory, first byte of a word on top
  logic [7:0]  model [MEM_BYTES];
  logic [63:0] stream_data [8];

  int tbl_op [MAX_ENTRIES];
  int tbl_addr [MAX_ENTRIES];
  int tbl_len [MAX_ENTRIES];
  int num_entries;

  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;
  int          busy_seen;
  int          error_seen;
  int          fill_busy;
  int          entry_idx;

  mem_subsystem mem_subsystem_i (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_read_64    (i_read_64),
    .i_write_64   (i_write_64),
    .i_write_data (i_write_data),
    .i_byte_addr  (i_byte_addr),
    .o_busy       (o_busy),
    .o_error      (o_error),
    .o_data       (o_data)
  );

  always #5 i_clk = ~i_clk;

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic add_entry(input int op, input int addr, input int len);
    tbl_op[num_entries]   = op;
    tbl_addr[num_entries] = addr;
    tbl_len[num_entries]  = len;
    num_entries++;
  endtask

  // eight bytes from the model starting at any byte, wrapping past the end
  function automatic logic [63:0] model_word(input int addr);
    logic [63:0] word;
    int          k;
    word = '0;
    for (k = 0; k < 8; k++) begin
      word = {word[55:0], model[(addr + k) % MEM_BYTES]};
    end
    return word;
  endfunction

  // the first count bytes of the stream data land at consecutive byte addresses
  task automatic model_store(input int addr, input int count);
    int j;
    for (j = 0; j < count; j++) begin
      model[(addr + j) % MEM_BYTES] = stream_data[j / 8][63 - 8 * (j % 8) -: 8];
    end
  endtask

  // o_data must be zero in every cycle that follows no read
  task automatic sample_status();
    if (o_busy) begin
      busy_seen++;
    end
    if (o_error) begin
      error_seen++;
    end
    check("o_data", 64'd0, o_data);
  endtask

  task automatic do_read(input int addr);
    @(negedge i_clk);
    i_read_64        = 1'b1;
    i_byte_addr.flat = addr[ADDR_BITS-1:0];
    @(negedge i_clk);
    check("o_data", model_word(addr), o_data);
    check("o_busy", 64'd0, {63'd0, o_busy});
    check("o_error", 64'd0, {63'd0, o_error});
    i_read_64 = 1'b0;
    @(negedge i_clk);
    check("o_data", 64'd0, o_data);
  endtask

  // count good writes at consecutive words, then one write at a wrong word if bad
  task automatic do_stream(input int addr, input int count, input bit bad);
    int lane;
    int writes;
    int i;
    int exp_busy;
    int kept;
    busy_seen  = 0;
    error_seen = 0;
    lane       = addr % 8;
    writes     = bad ? count + 1 : count;
    for (i = 0; i < writes; i++) begin
      @(negedge i_clk);
      if (i > 0) begin
        sample_status();
      end
      stream_data[i] = {$urandom, $urandom};
      i_write_64     = 1'b1;
      i_write_data   = stream_data[i];
      // the broken continuation skips one word past the expected one
      if (bad && i == count) begin
        i_byte_addr.flat = ADDR_BITS'((addr + 8 * (count + 1)) % MEM_BYTES);
      end else begin
        i_byte_addr.flat = ADDR_BITS'((addr + 8 * i) % MEM_BYTES);
      end
    end
    @(negedge i_clk);
    sample_status();
    i_write_64 = 1'b0;
    while (o_busy) begin
      @(negedge i_clk);
      sample_status();
    end
    // aligned writes never raise busy, streams hold it for count plus tail
    exp_busy = (lane == 0) ? 0 : count + 1;
    check("o_busy cycles", 64'(exp_busy), 64'(busy_seen));
    check("o_error cycles", bad ? 64'd1 : 64'd0, 64'(error_seen));
    // a fault drops the tail, so the last lane bytes of the stream are lost
    kept = bad ? 8 * count - lane : 8 * count;
    model_store(addr, kept);
  endtask

  task automatic load_table();
    num_entries = 0;
    add_entry(OP_READ, 0, 0);
    add_entry(OP_READ, 3, 0);
    add_entry(OP_READ, 509, 0);
    add_entry(OP_WRITE, 16, 1);
    add_entry(OP_READ, 16, 0);
    add_entry(OP_WRITE, 41, 1);
    add_entry(OP_READ, 40, 0);
    add_entry(OP_READ, 48, 0);
    add_entry(OP_READ, 41, 0);
    add_entry(OP_WRITE, 87, 1);
    add_entry(OP_READ, 80, 0);
    add_entry(OP_READ, 88, 0);
    add_entry(OP_READ, 87, 0);
    add_entry(OP_STREAM, 242, 2);
    add_entry(OP_READ, 240, 0);
    add_entry(OP_READ, 256, 0);
    add_entry(OP_STREAM, 325, 4);
    add_entry(OP_READ, 320, 0);
    add_entry(OP_READ, 352, 0);
    add_entry(OP_READ, 333, 0);
    // this stream runs over the last word into words 0 and 1
    add_entry(OP_STREAM, 499, 3);
    add_entry(OP_READ, 496, 0);
    add_entry(OP_READ, 8, 0);
    add_entry(OP_READ, 499, 0);
    add_entry(OP_BAD_STREAM, 406, 1);
    add_entry(OP_READ, 400, 0);
    add_entry(OP_READ, 408, 0);
    add_entry(OP_BAD_STREAM, 434, 2);
    add_entry(OP_READ, 432, 0);
    add_entry(OP_READ, 440, 0);
    add_entry(OP_READ, 448, 0);
  endtask

  initial begin : watchdog
    cycle_count = 0;
    @(posedge i_clk);
    while (cycle_count < cycle_limit) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    i_clk            = 1'b0;
    i_areset         = 1'b1;
    i_read_64        = 1'b0;
    i_write_64       = 1'b0;
    i_write_data     = '0;
    i_byte_addr.flat = '0;
    errors           = 0;
    checks           = 0;
    // one seed for all write data of the run
    void'($urandom(32'h97d7_0bf5));
    load_table();
    cycle_limit = NUM_WORDS + 20 * num_entries + 200;
    for (entry_idx = 0; entry_idx < MEM_BYTES; entry_idx++) begin
      model[entry_idx] = INIT_WORD[63 - 8 * (entry_idx % 8) -: 8];
    end
    repeat (3) @(negedge i_clk);
    check("o_busy", 64'd0, {63'd0, o_busy});
    check("o_error", 64'd0, {63'd0, o_error});
    check("o_data", 64'd0, o_data);
    i_areset = 1'b0;
    // the fill keeps busy high for one cycle per word
    fill_busy = 0;
    @(negedge i_clk);
    while (o_busy) begin
      fill_busy++;
      @(negedge i_clk);
    end
    check("o_busy fill cycles", 64'(NUM_WORDS), 64'(fill_busy));
    for (entry_idx = 0; entry_idx < num_entries; entry_idx++) begin
      case (tbl_op[entry_idx])
        OP_READ: begin
          do_read(tbl_addr[entry_idx]);
        end
        OP_BAD_STREAM: begin
          do_stream(tbl_addr[entry_idx], tbl_len[entry_idx], 1'b1);
        end
        default: begin
          do_stream(tbl_addr[entry_idx], tbl_len[entry_idx], 1'b0);
        end
      endcase
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/bram_dpge.sv
// dual-port block RAM with a shared enable and registered read data
// port A writes and reads, port B only reads
module bram_dpge #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 64
) (
  input  logic                  i_clk,
  input  logic                  i_en,
  input  logic                  i_we_a,
  input  logic [ADDR_WIDTH-1:0] i_addr_a,
  input  logic [ADDR_WIDTH-1:0] i_addr_b,
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic [DATA_WIDTH-1:0] o_data_a,
  output logic [DATA_WIDTH-1:0] o_data_b
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // both ports return the contents from before a write in the same cycle,
  // the controller relies on that when it merges old bytes into a word
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_we_a) begin
        mem[i_addr_a] <= i_data;
      end
      o_data_a <= mem[i_addr_a];
      o_data_b <= mem[i_addr_b];
    end
  end

  // an unknown address while enabled would corrupt an arbitrary word
  a_addr_known : assert property (
    @(posedge i_clk) i_en |-> !$isunknown({i_addr_a, i_addr_b})
  ) else $error("bram address unknown while enabled");

endmodule

// File: verilog/mem_addr_pkg.sv
// address types of the memory subsystem
// byte address union with its flat and word/lane views
`include "mem_consts.svh"

package mem_addr_pkg;

  // byte offset inside one 64-bit word, lane 0 holds the top byte
  typedef logic [`MEM_LANE_BITS-1:0] lane_t;

  // index of one storage word
  typedef logic [`MEM_ADDR_WIDTH-1:0] word_addr_t;

  localparam int BYTE_ADDR_BITS = `MEM_ADDR_WIDTH + `MEM_LANE_BITS;

  // the word index sits above the lane, so both views share one layout
  typedef struct packed {
    word_addr_t word;
    lane_t      lane;
  } byte_addr_fields_t;

  typedef union packed {
    logic [BYTE_ADDR_BITS-1:0] flat;
    byte_addr_fields_t         fields;
  } byte_addr_u;

endpackage

// File: verilog/mem_consts.svh
// default sizes of the byte-addressed memory subsystem
// and the pattern written by the reset fill
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word-address bits, 64 words of storage by default
`define MEM_ADDR_WIDTH 6

// one storage word and the byte-lane offset inside it
`define MEM_DATA_WIDTH 64
`define MEM_LANE_BITS 3

// the controller fills every word with this value after reset when enabled
`define MEM_INIT_ON_RESET 1
`define MEM_INIT_VALUE 64'h0123_4567_89ab_cdef

`endif

// File: verilog/mem_fsm_pkg.sv
// controller state encoding of the memory subsystem
package mem_fsm_pkg;

  localparam int STATE_BITS = 3;

  // the stream states follow each other in the order of a streamed write
  typedef enum logic [STATE_BITS-1:0] {
    // every word is written with the init value
    FILL        = 3'd0,
    IDLE        = 3'd1,
    // first word of a stream, merged with its old leading bytes
    STREAM_HEAD = 3'd2,
    STREAM_BODY = 3'd3,
    // last word, merged with its old trailing bytes
    STREAM_TAIL = 3'd4,
    // one cycle of error after a broken stream
    FAULT       = 3'd7
  } ctrl_state_e;

endpackage

// File: verilog/mem_subsystem.sv
// top level of the byte-addressed memory subsystem
// splits the byte address into word and lane for the controller
`include "mem_consts.svh"

module mem_subsystem (
  input  logic                                    i_clk,
  input  logic                                    i_areset,
  input  logic                                    i_read_64,
  input  logic                                    i_write_64,
  input  logic [`MEM_DATA_WIDTH-1:0]              i_write_data,
  input  logic [mem_addr_pkg::BYTE_ADDR_BITS-1:0] i_byte_addr,
  output logic                                    o_busy,
  output logic                                    o_error,
  output logic [`MEM_DATA_WIDTH-1:0]              o_data
);

  // the flat byte number and its word and lane view are the same bits
  mem_addr_pkg::byte_addr_u byte_addr;

  assign byte_addr.flat = i_byte_addr;

  memory_ctrl #(
    .ADDR_WIDTH    (`MEM_ADDR_WIDTH),
    .INIT_ON_RESET (`MEM_INIT_ON_RESET),
    .INIT_VALUE    (`MEM_INIT_VALUE)
  ) memory_ctrl_i (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_read_64    (i_read_64),
    .i_write_64   (i_write_64),
    .i_write_data (i_write_data),
    .i_addr_hi    (byte_addr.fields.word),
    .i_addr_lo    (byte_addr.fields.lane),
    .o_error      (o_error),
    .o_busy       (o_busy),
    .o_data       (o_data)
  );

endmodule

// File: verilog/memory_ctrl.sv
// controller for a byte-addressed memory of 64-bit words
// reset fill, aligned and streamed unaligned writes, unaligned reads
`include "mem_consts.svh"

module memory_ctrl #(
  parameter int                     ADDR_WIDTH    = `MEM_ADDR_WIDTH,
  parameter bit                     INIT_ON_RESET = 1'b1,
  parameter logic [`MEM_DATA_WIDTH-1:0] INIT_VALUE = '0
) (
  input  logic                          i_clk,
  input  logic                          i_areset,
  input  logic                          i_read_64,
  input  logic                          i_write_64,
  input  logic [`MEM_DATA_WIDTH-1:0]    i_write_data,
  input  mem_addr_pkg::word_addr_t      i_addr_hi,
  input  mem_addr_pkg::lane_t           i_addr_lo,
  output logic                          o_error,
  output logic                          o_busy,
  output logic [`MEM_DATA_WIDTH-1:0]    o_data
);

  localparam int DATA_WIDTH = `MEM_DATA_WIDTH;
  localparam int SHIFT_BITS = `MEM_LANE_BITS + 3;
  localparam logic [ADDR_WIDTH-1:0] MAX_ADDR = '1;

  mem_fsm_pkg::ctrl_state_e state_q;
  mem_fsm_pkg::ctrl_state_e state_d;

  // port A holds the word being written, port B the word after it
  logic [ADDR_WIDTH-1:0] addr_a_q;
  logic [ADDR_WIDTH-1:0] addr_a_d;
  logic [ADDR_WIDTH-1:0] addr_b_q;
  logic [ADDR_WIDTH-1:0] addr_b_d;
  mem_addr_pkg::lane_t   lane_q;
  mem_addr_pkg::lane_t   lane_d;
  logic                  read_q;
  logic                  read_d;
  logic                  busy_q;

  // user write data one and two cycles back
  logic [DATA_WIDTH-1:0] write_d1_q;
  logic [DATA_WIDTH-1:0] write_d2_q;

  logic [ADDR_WIDTH-1:0] req_word;
  logic [ADDR_WIDTH-1:0] req_word_p1;
  logic [ADDR_WIDTH-1:0] addr_a;
  logic [ADDR_WIDTH-1:0] addr_b;
  logic [DATA_WIDTH-1:0] data_a;
  logic [DATA_WIDTH-1:0] data_b;
  logic                  ram_en;
  logic                  ram_we;
  logic [DATA_WIDTH-1:0] ram_wdata;
  logic                  idle;
  logic                  idle_write;

  logic [SHIFT_BITS-1:0]   shift_bits;
  logic [DATA_WIDTH-1:0]   lane_mask;
  logic [DATA_WIDTH-1:0]   head_word;
  logic [2*DATA_WIDTH-1:0] body_pair;
  logic [2*DATA_WIDTH-1:0] tail_pair;
  logic [DATA_WIDTH-1:0]   tail_word;
  logic [2*DATA_WIDTH-1:0] read_pair;

  assign req_word    = i_addr_hi;
  // the next word wraps from the last word back to word 0
  assign req_word_p1 = req_word + 1'b1;

  assign idle       = (state_q == mem_fsm_pkg::IDLE);
  // a read in the same cycle wins over the write
  assign idle_write = idle && i_write_64 && !i_read_64;

  // in idle the RAM follows the request directly so that a read is one cycle
  assign addr_a = idle ? req_word    : addr_a_q;
  assign addr_b = idle ? req_word_p1 : addr_b_q;
  assign ram_en = !idle || i_read_64 || i_write_64;

  // the registered busy flag matches the state except during reset and the
  // single priming cycle of the fill
  assign o_busy  = busy_q;
  assign o_error = (state_q == mem_fsm_pkg::FAULT);

  bram_dpge #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) bram_i (
    .i_clk    (i_clk),
    .i_en     (ram_en),
    .i_we_a   (ram_we),
    .i_addr_a (addr_a),
    .i_addr_b (addr_b),
    .i_data   (ram_wdata),
    .o_data_a (data_a),
    .o_data_b (data_b)
  );

  // byte shift for the registered lane and the mask of the bytes below it
  assign shift_bits = {lane_q, 3'b000};
  assign lane_mask  = {DATA_WIDTH{1'b1}} >> shift_bits;

  // head keeps the old bytes in front of the lane, then the first data bytes
  assign head_word = (data_a & ~lane_mask) | (write_d1_q >> shift_bits);
  // body takes the tail of the older data word and the head of the newer one
  assign body_pair = {write_d2_q, write_d1_q} >> shift_bits;
  // tail puts the last data bytes on top and keeps the old bytes after them
  assign tail_pair = {write_d2_q, {DATA_WIDTH{1'b0}}} >> shift_bits;
  assign tail_word = tail_pair[DATA_WIDTH-1:0] | (data_b & lane_mask);

  // a read joins word and word+1, then drops the bytes in front of the lane
  assign read_pair = {data_a, data_b} << shift_bits;
  assign o_data    = read_q ? read_pair[2*DATA_WIDTH-1:DATA_WIDTH] : '0;

  always_comb begin
    ram_we    = 1'b0;
    ram_wdata = '0;
    case (state_q)
      // the first fill cycle after reset only primes the busy flag
      mem_fsm_pkg::FILL: begin
        ram_we    = busy_q;
        ram_wdata = INIT_VALUE;
      end
      // aligned writes go straight to the RAM, unaligned ones wait for the
      // old word to come back
      mem_fsm_pkg::IDLE: begin
        if (idle_write && i_addr_lo == '0) begin
          ram_we    = 1'b1;
          ram_wdata = i_write_data;
        end
      end
      mem_fsm_pkg::STREAM_HEAD: begin
        ram_we    = 1'b1;
        ram_wdata = head_word;
      end
      mem_fsm_pkg::STREAM_BODY: begin
        ram_we    = 1'b1;
        ram_wdata = body_pair[DATA_WIDTH-1:0];
      end
      mem_fsm_pkg::STREAM_TAIL: begin
        ram_we    = 1'b1;
        ram_wdata = tail_word;
      end
      default: begin
        ram_we    = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_d  = state_q;
    addr_a_d = addr_a_q;
    addr_b_d = addr_b_q;
    lane_d   = lane_q;
    read_d   = 1'b0;
    case (state_q)
      // port A counts through every word once
      mem_fsm_pkg::FILL: begin
        if (busy_q) begin
          if (addr_a_q == MAX_ADDR) begin
            state_d = mem_fsm_pkg::IDLE;
          end else begin
            addr_a_d = addr_a_q + 1'b1;
          end
        end
      end
      mem_fsm_pkg::IDLE: begin
        lane_d = i_addr_lo;
        if (i_read_64) begin
          read_d = 1'b1;
        end else if (idle_write && i_addr_lo != '0) begin
          state_d  = mem_fsm_pkg::STREAM_HEAD;
          addr_a_d = req_word;
          addr_b_d = req_word_p1;
        end
      end
      // a continuation must name the word that port B is holding
      mem_fsm_pkg::STREAM_HEAD, mem_fsm_pkg::STREAM_BODY: begin
        if (i_write_64) begin
          if (req_word != addr_b_q) begin
            state_d = mem_fsm_pkg::FAULT;
          end else begin
            state_d  = mem_fsm_pkg::STREAM_BODY;
            addr_a_d = req_word;
            addr_b_d = req_word_p1;
          end
        end else begin
          // the word after the stream gets the remaining bytes
          state_d  = mem_fsm_pkg::STREAM_TAIL;
          addr_a_d = addr_b_q;
        end
      end
      mem_fsm_pkg::STREAM_TAIL: begin
        if (i_write_64) begin
          state_d = mem_fsm_pkg::FAULT;
        end else begin
          state_d = mem_fsm_pkg::IDLE;
        end
      end
      default: begin
        state_d = mem_fsm_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      if (INIT_ON_RESET) begin
        state_q <= mem_fsm_pkg::FILL;
      end else begin
        state_q <= mem_fsm_pkg::IDLE;
      end
      addr_a_q <= '0;
      addr_b_q <= '0;
      lane_q   <= '0;
      read_q   <= 1'b0;
      busy_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      addr_a_q <= addr_a_d;
      addr_b_q <= addr_b_d;
      lane_q   <= lane_d;
      read_q   <= read_d;
      busy_q   <= (state_d != mem_fsm_pkg::IDLE);
    end
  end

  // write data is shifted every cycle, a stream only looks at it when valid
  always_ff @(posedge i_clk) begin
    write_d1_q <= i_write_data;
    write_d2_q <= write_d1_q;
  end

  a_fault_to_idle : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (state_q == mem_fsm_pkg::FAULT) |=> (state_q == mem_fsm_pkg::IDLE)
  ) else $error("controller did not return to idle after a fault");

  // reads are only legal when the user sees the controller free
  a_no_read_busy : assert property (
    @(posedge i_clk) disable iff (i_areset) o_busy |-> !i_read_64
  ) else $error("read issued while busy");

  a_error_pulse : assert property (
    @(posedge i_clk) disable iff (i_areset) o_error |=> !o_error
  ) else $error("error held for more than one cycle");

endmodule
